// File: filelist.f
src/lsu_cfg_pkg.sv
src/load_op_pkg.sv
src/load_ctrl_fsm.sv
src/load_buffer.sv
src/load_result_align.sv
src/load_unit.sv
tb/tb_load_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the load unit testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f filelist.f --top-module tb_load_unit \
  --Mdir obj_dir -o tb_load_unit
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_load_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi

// File: src/load_buffer.sv
// needs 2 <= NrLoadBufEntries <= 2**DcacheIdWidth; response id must name a live slot
`timescale 1ns/1ps

module load_buffer
  import lsu_cfg_pkg::*;
  import load_op_pkg::*;
#(
  parameter int unsigned NrLoadBufEntries = 4,
  parameter int unsigned DcacheIdWidth    = 2
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  input  logic                     w_i,
  input  trans_id_t                trans_id_i,
  input  logic [ALIGN_BITS-1:0]    offset_i,
  input  load_op_e                 op_i,
  input  logic                     data_rvalid_i,
  input  logic [DcacheIdWidth-1:0] data_rid_i,
  output logic                     full_o,
  output logic [DcacheIdWidth-1:0] windex_o,
  output logic                     rd_valid_o,
  output trans_id_t                rd_trans_id_o,
  output logic [ALIGN_BITS-1:0]    rd_offset_o,
  output load_op_e                 rd_op_o
);

  logic [NrLoadBufEntries-1:0] valid_d, valid_q;
  logic [NrLoadBufEntries-1:0] flushed_d, flushed_q;
  // slot payload
  trans_id_t                   trans_id_q [NrLoadBufEntries];
  logic [ALIGN_BITS-1:0]       offset_q   [NrLoadBufEntries];
  load_op_e                    op_q       [NrLoadBufEntries];

  assign full_o = &valid_q;

  // ------------------------------
  // lowest free slot
  // ------------------------------
  always_comb begin
    windex_o = '0;
    // scan downwards so the lowest free slot wins
    for (int i = NrLoadBufEntries - 1; i >= 0; i--) begin
      if (!valid_q[i]) windex_o = DcacheIdWidth'(i);
    end
  end

  // ------------------------------
  // slot flags
  // ------------------------------
  always_comb begin
    valid_d   = valid_q;
    flushed_d = flushed_q;
    // every outstanding load is dropped on return
    if (flush_i) flushed_d = '1;
    // a response frees its slot in the same cycle
    if (data_rvalid_i) valid_d[data_rid_i] = 1'b0;
    if (w_i) begin
      valid_d[windex_o]   = 1'b1;
      flushed_d[windex_o] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= '0;
      flushed_q <= '0;
    end else begin
      valid_q   <= valid_d;
      flushed_q <= flushed_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (w_i) begin
      trans_id_q[windex_o] <= trans_id_i;
      offset_q[windex_o]   <= offset_i;
      op_q[windex_o]       <= op_i;
    end
  end

  // read port indexed by the response id
  assign rd_valid_o    = data_rvalid_i && !flushed_q[data_rid_i];
  assign rd_trans_id_o = trans_id_q[data_rid_i];
  assign rd_offset_o   = offset_q[data_rid_i];
  assign rd_op_o       = op_q[data_rid_i];

endmodule

// File: src/load_ctrl_fsm.sv
// translation is flat: the tag is the upper vaddr bits; request inputs must hold until pop
`timescale 1ns/1ps

module load_ctrl_fsm
  import lsu_cfg_pkg::*;
  import load_op_pkg::*;
#(
  parameter int unsigned NrLoadBufEntries = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        flush_i,
  input  logic                        valid_i,
  input  vaddr_t                      vaddr_i,
  input  load_op_e                    op_i,
  input  logic                        page_offset_matches_i,
  input  logic                        data_gnt_i,
  input  logic                        ldbuf_full_i,
  output logic                        pop_ld_o,
  output logic                        data_req_o,
  output size_e                       data_size_o,
  output logic [DCACHE_TAG_WIDTH-1:0] address_tag_o,
  output logic                        tag_valid_o,
  output logic                        kill_req_o,
  output logic                        ldbuf_w_o
);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_PAGE_OFFSET,
    WAIT_GNT,
    SEND_TAG,
    WAIT_FLUSH
  } state_e;

  state_e                      state_d, state_q;
  logic [DCACHE_TAG_WIDTH-1:0] tag_q;
  logic                        accept_req;
  logic                        issue_req;

  // ------------------------------
  // transfer size from the operation
  // ------------------------------
  always_comb begin
    unique case (op_i)
      LB, LBU: data_size_o = BYTE;
      LH, LHU: data_size_o = HALF;
      LW, LWU: data_size_o = WORD;
      default: data_size_o = DOUBLE;
    endcase
  end

  // no new request while a flush is pending
  assign accept_req = valid_i && !ldbuf_full_i && !flush_i;

  // ------------------------------
  // load control
  // ------------------------------
  always_comb begin
    state_d     = state_q;
    issue_req   = 1'b0;
    tag_valid_o = 1'b0;
    kill_req_o  = 1'b0;

    unique case (state_q)
      IDLE, SEND_TAG: begin
        // tag of the previous grant goes out in SEND_TAG
        if (state_q == SEND_TAG) begin
          tag_valid_o = 1'b1;
          state_d     = IDLE;
        end
        if (accept_req) begin
          if (!page_offset_matches_i) begin
            // index goes out right away
            issue_req = 1'b1;
            state_d   = data_gnt_i ? SEND_TAG : WAIT_GNT;
          end else begin
            // a store to the same offset is still pending
            state_d = WAIT_PAGE_OFFSET;
          end
        end
      end
      WAIT_PAGE_OFFSET: begin
        if (!page_offset_matches_i) state_d = WAIT_GNT;
      end
      WAIT_GNT: begin
        // hold the request until the cache grants it
        issue_req = !flush_i;
        if (data_gnt_i) state_d = SEND_TAG;
      end
      WAIT_FLUSH: begin
        // kill whatever tag the cache is still waiting for
        kill_req_o  = 1'b1;
        tag_valid_o = 1'b1;
        state_d     = IDLE;
      end
      default: state_d = IDLE;
    endcase

    // flush wins over every other transition
    if (flush_i) state_d = WAIT_FLUSH;
  end

  assign data_req_o    = issue_req;
  assign ldbuf_w_o     = issue_req & data_gnt_i;
  // the granted load leaves the upstream queue
  assign pop_ld_o      = ldbuf_w_o;
  assign address_tag_o = tag_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // tag bits captured on the grant, sent in the following cycle
  always_ff @(posedge clk_i) begin
    if (ldbuf_w_o) tag_q <= vaddr_i[DCACHE_INDEX_WIDTH +: DCACHE_TAG_WIDTH];
  end

endmodule

// File: src/load_op_pkg.sv
// integer loads only; no floating-point or hypervisor load encodings exist here
package load_op_pkg;

  // ------------------------------
  // load operations
  // ------------------------------
  // signed variants extend the top bit of the loaded field,
  // U variants zero-fill
  typedef enum logic [2:0] {
    LB,
    LBU,
    LH,
    LHU,
    LW,
    LWU,
    LD
  } load_op_e;

  // ------------------------------
  // transfer sizes on the cache port
  // ------------------------------
  // encoded as log2 of the byte count
  typedef enum logic [1:0] {
    BYTE,
    HALF,
    WORD,
    DOUBLE
  } size_e;

endpackage

// File: src/load_result_align.sv
// offsets must be naturally aligned for the size; misaligned loads give wrapped sign bits
`timescale 1ns/1ps

module load_result_align
  import lsu_cfg_pkg::*;
  import load_op_pkg::*;
(
  input  xlen_t                 rdata_i,
  input  logic [ALIGN_BITS-1:0] offset_i,
  input  load_op_e              op_i,
  output xlen_t                 result_o
);

  xlen_t                 shifted_data;
  logic [XLEN/8-1:0]     sign_bits;
  logic [ALIGN_BITS-1:0] sign_offset;
  logic                  is_signed;
  logic                  sign_bit;

  // ------------------------------
  // realign to bit 0
  // ------------------------------
  assign shifted_data = rdata_i >> {offset_i, 3'b000};

  // ------------------------------
  // sign bit, in parallel with the shift
  // ------------------------------
  // top bit of every byte of the raw word
  for (genvar i = 0; i < XLEN / 8; i++) begin : gen_sign_bits
    assign sign_bits[i] = rdata_i[(i+1)*8-1];
  end

  assign is_signed = op_i inside {LB, LH, LW};

  // byte holding the msb of the loaded field
  always_comb begin
    unique case (op_i)
      LW:      sign_offset = offset_i + ALIGN_BITS'(3);
      LH:      sign_offset = offset_i + ALIGN_BITS'(1);
      default: sign_offset = offset_i;
    endcase
  end

  // unsigned loads pull the fill to 0
  assign sign_bit = is_signed && sign_bits[sign_offset];

  // ------------------------------
  // result mux
  // ------------------------------
  always_comb begin
    unique case (op_i)
      LW, LWU: result_o = {{XLEN - 32{sign_bit}}, shifted_data[31:0]};
      LH, LHU: result_o = {{XLEN - 16{sign_bit}}, shifted_data[15:0]};
      LB, LBU: result_o = {{XLEN - 8{sign_bit}}, shifted_data[7:0]};
      default: result_o = shifted_data;
    endcase
  end

endmodule

// File: src/load_unit.sv
// read-only cache port, no translation or exceptions; loads may retire out of order
`timescale 1ns/1ps

module load_unit
  import lsu_cfg_pkg::*;
  import load_op_pkg::*;
#(
  parameter int unsigned NrLoadBufEntries = DEFAULT_LDBUF_ENTRIES,
  parameter int unsigned DcacheIdWidth    = DEFAULT_DCACHE_ID_WIDTH
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  // upstream load request
  input  logic                          valid_i,
  input  trans_id_t                     trans_id_i,
  input  vaddr_t                        vaddr_i,
  input  load_op_e                      op_i,
  input  logic [XLEN/8-1:0]             be_i,
  output logic                          pop_ld_o,
  // store unit address check
  output logic [11:0]                   page_offset_o,
  input  logic                          page_offset_matches_i,
  // cache request
  output logic                          data_req_o,
  input  logic                          data_gnt_i,
  output logic [DCACHE_INDEX_WIDTH-1:0] address_index_o,
  output logic [DcacheIdWidth-1:0]      data_id_o,
  output logic [XLEN/8-1:0]             data_be_o,
  output size_e                         data_size_o,
  output logic [DCACHE_TAG_WIDTH-1:0]   address_tag_o,
  output logic                          tag_valid_o,
  output logic                          kill_req_o,
  // cache response
  input  logic                          data_rvalid_i,
  input  logic [DcacheIdWidth-1:0]      data_rid_i,
  input  xlen_t                         data_rdata_i,
  // writeback
  output logic                          valid_o,
  output trans_id_t                     trans_id_o,
  output xlen_t                         result_o
);

  logic                     ldbuf_w;
  logic                     ldbuf_full;
  logic [DcacheIdWidth-1:0] ldbuf_windex;
  logic                     rd_valid;
  trans_id_t                rd_trans_id;
  logic [ALIGN_BITS-1:0]    rd_offset;
  load_op_e                 rd_op;

  // ------------------------------
  // request side
  // ------------------------------
  assign page_offset_o   = vaddr_i[11:0];
  assign address_index_o = vaddr_i[DCACHE_INDEX_WIDTH-1:0];
  // the cache id is the buffer slot
  assign data_id_o       = ldbuf_windex;
  assign data_be_o       = be_i;

  load_ctrl_fsm #(
    .NrLoadBufEntries(NrLoadBufEntries)
  ) load_ctrl_fsm_i (
    .clk_i,
    .rst_ni,
    .flush_i,
    .valid_i,
    .vaddr_i,
    .op_i,
    .page_offset_matches_i,
    .data_gnt_i,
    .ldbuf_full_i (ldbuf_full),
    .pop_ld_o,
    .data_req_o,
    .data_size_o,
    .address_tag_o,
    .tag_valid_o,
    .kill_req_o,
    .ldbuf_w_o    (ldbuf_w)
  );

  load_buffer #(
    .NrLoadBufEntries(NrLoadBufEntries),
    .DcacheIdWidth   (DcacheIdWidth)
  ) load_buffer_i (
    .clk_i,
    .rst_ni,
    .flush_i,
    .w_i          (ldbuf_w),
    .trans_id_i,
    .offset_i     (vaddr_i[ALIGN_BITS-1:0]),
    .op_i,
    .data_rvalid_i,
    .data_rid_i,
    .full_o       (ldbuf_full),
    .windex_o     (ldbuf_windex),
    .rd_valid_o   (rd_valid),
    .rd_trans_id_o(rd_trans_id),
    .rd_offset_o  (rd_offset),
    .rd_op_o      (rd_op)
  );

  // ------------------------------
  // response side
  // ------------------------------
  assign valid_o    = rd_valid;
  assign trans_id_o = rd_trans_id;

  load_result_align load_result_align_i (
    .rdata_i (data_rdata_i),
    .offset_i(rd_offset),
    .op_i    (rd_op),
    .result_o
  );

endmodule

// File: src/lsu_cfg_pkg.sv
// cache port and load unit sizes; tag plus index must cover the whole virtual address
package lsu_cfg_pkg;

  // ------------------------------
  // data path
  // ------------------------------
  localparam int unsigned XLEN       = 64;
  // byte offset bits inside one word
  localparam int unsigned ALIGN_BITS = 3;

  // ------------------------------
  // cache port
  // ------------------------------
  localparam int unsigned DCACHE_INDEX_WIDTH = 12;
  localparam int unsigned DCACHE_TAG_WIDTH   = 44;
  localparam int unsigned VLEN               = 56;
  localparam int unsigned TRANS_ID_BITS      = 3;

  // default load buffer depth and response id width
  localparam int unsigned DEFAULT_LDBUF_ENTRIES   = 4;
  localparam int unsigned DEFAULT_DCACHE_ID_WIDTH = 2;

  typedef logic [XLEN-1:0]          xlen_t;
  typedef logic [VLEN-1:0]          vaddr_t;
  typedef logic [TRANS_ID_BITS-1:0] trans_id_t;

endpackage

// File: tb/tb_load_unit.sv
// single-clock directed testbench; cache model answers by slot id, gnt held high unless a test drops it
`timescale 1ns/1ps

module tb_load_unit
  import lsu_cfg_pkg::*;
  import load_op_pkg::*;
;

  localparam int NrEntries   = DEFAULT_LDBUF_ENTRIES;
  localparam int IdWidth     = DEFAULT_DCACHE_ID_WIDTH;
  localparam int MaxLoads    = 8;
  localparam int NumTests    = 5;
  localparam int CycleBudget = 300;
  // reset cycles plus the budget of every test, in ns
  localparam int TimeoutNs   = (16 + NumTests * CycleBudget) * 10;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          flush_i;
  logic                          valid_i;
  trans_id_t                     trans_id_i;
  vaddr_t                        vaddr_i;
  load_op_e                      op_i;
  logic [XLEN/8-1:0]             be_i;
  logic                          pop_ld_o;
  logic [11:0]                   page_offset_o;
  logic                          page_offset_matches_i;
  logic                          data_req_o;
  logic                          data_gnt_i;
  logic [DCACHE_INDEX_WIDTH-1:0] address_index_o;
  logic [IdWidth-1:0]            data_id_o;
  logic [XLEN/8-1:0]             data_be_o;
  size_e                         data_size_o;
  logic [DCACHE_TAG_WIDTH-1:0]   address_tag_o;
  logic                          tag_valid_o;
  logic                          kill_req_o;
  logic                          data_rvalid_i;
  logic [IdWidth-1:0]            data_rid_i;
  xlen_t                         data_rdata_i;
  logic                          valid_o;
  trans_id_t                     trans_id_o;
  xlen_t                         result_o;

  // per-load stimulus and the slot it landed in
  trans_id_t                   ld_id   [MaxLoads];
  vaddr_t                      ld_addr [MaxLoads];
  load_op_e                    ld_op   [MaxLoads];
  xlen_t                       ld_data [MaxLoads];
  logic [IdWidth-1:0]          ld_slot [MaxLoads];

  logic [31:0]                 rng_state = 32'h2f2e;
  int                          pop_count = 0;
  int                          tag_count = 0;
  logic                        tag_due   = 1'b0;
  logic [DCACHE_TAG_WIDTH-1:0] exp_tag;

  load_unit #(
    .NrLoadBufEntries(NrEntries),
    .DcacheIdWidth   (IdWidth)
  ) load_unit_i (
    .clk_i, .rst_ni, .flush_i, .valid_i, .trans_id_i, .vaddr_i, .op_i, .be_i, .pop_ld_o,
    .page_offset_o, .page_offset_matches_i, .data_req_o, .data_gnt_i, .address_index_o,
    .data_id_o, .data_be_o, .data_size_o, .address_tag_o, .tag_valid_o, .kill_req_o,
    .data_rvalid_i, .data_rid_i, .data_rdata_i, .valid_o, .trans_id_o, .result_o
  );

  always #5 clk_i = ~clk_i;

  // ------------------------------
  // reporting and compares
  // ------------------------------
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_result(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) fail_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
  endtask

  task automatic check_id(input string name, input trans_id_t got, input trans_id_t exp);
    if (got !== exp) fail_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) fail_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
  endtask

  task automatic check_tag(input string name, input logic [DCACHE_TAG_WIDTH-1:0] got,
                           input logic [DCACHE_TAG_WIDTH-1:0] exp);
    if (got !== exp) fail_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
  endtask

  task automatic check_index(input string name, input logic [DCACHE_INDEX_WIDTH-1:0] got,
                             input logic [DCACHE_INDEX_WIDTH-1:0] exp);
    if (got !== exp) fail_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
  endtask

  task automatic check_slot(input string name, input logic [IdWidth-1:0] got,
                            input logic [IdWidth-1:0] exp);
    if (got !== exp) fail_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
  endtask

  task automatic check_be(input string name, input logic [XLEN/8-1:0] got,
                          input logic [XLEN/8-1:0] exp);
    if (got !== exp) fail_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
  endtask

  task automatic check_size(input string name, input size_e got, input size_e exp);
    if (got !== exp) fail_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) fail_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
  endtask

  // ------------------------------
  // reference model
  // ------------------------------
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int op_bytes(input load_op_e op);
    case (op)
      LB, LBU: return 1;
      LH, LHU: return 2;
      LW, LWU: return 4;
      default: return 8;
    endcase
  endfunction

  // size code is log2 of the byte count
  function automatic size_e expected_size(input load_op_e op);
    case (op_bytes(op))
      1:       return BYTE;
      2:       return HALF;
      4:       return WORD;
      default: return DOUBLE;
    endcase
  endfunction

  // one enable per loaded byte, starting at the address offset
  function automatic logic [XLEN/8-1:0] load_be(input vaddr_t addr, input load_op_e op);
    return 8'(((1 << op_bytes(op)) - 1) << addr[2:0]);
  endfunction

  // shift the field down to bit 0, then extend from its own top bit
  function automatic xlen_t expected_load(input xlen_t data, input logic [2:0] offset,
                                          input load_op_e op);
    xlen_t field;
    field = data >> (8 * offset);
    case (op)
      LB:      return {{XLEN-8{field[7]}}, field[7:0]};
      LBU:     return {{XLEN-8{1'b0}}, field[7:0]};
      LH:      return {{XLEN-16{field[15]}}, field[15:0]};
      LHU:     return {{XLEN-16{1'b0}}, field[15:0]};
      LW:      return {{XLEN-32{field[31]}}, field[31:0]};
      LWU:     return {{XLEN-32{1'b0}}, field[31:0]};
      default: return field;
    endcase
  endfunction

  // random op, naturally aligned offset, random data
  task automatic make_load(input int idx);
    load_op_e op;
    op = load_op_e'(3'(next_rand() % 7));
    ld_op[idx]         = op;
    ld_addr[idx]       = vaddr_t'({next_rand(), next_rand()});
    ld_addr[idx][2:0]  = 3'(next_rand()) & 3'(8 - op_bytes(op));
    ld_data[idx]       = {next_rand(), next_rand()};
    ld_id[idx]         = trans_id_t'(idx + 1);
  endtask

  // ------------------------------
  // stimulus and cache model
  // ------------------------------
  task automatic drive_load(input int idx);
    @(negedge clk_i);
    valid_i    = 1'b1;
    trans_id_i = ld_id[idx];
    vaddr_i    = ld_addr[idx];
    op_i       = ld_op[idx];
    be_i       = load_be(ld_addr[idx], ld_op[idx]);
  endtask

  // returns inside the grant cycle, with the request fields checked
  task automatic wait_pop(input int idx);
    #1;
    while (!pop_ld_o) begin
      @(negedge clk_i);
      #1;
    end
    ld_slot[idx] = data_id_o;
    check_index("address_index_o", address_index_o, ld_addr[idx][DCACHE_INDEX_WIDTH-1:0]);
    check_index("page_offset_o", page_offset_o, ld_addr[idx][11:0]);
    check_be("data_be_o", data_be_o, load_be(ld_addr[idx], ld_op[idx]));
    check_size("data_size_o", data_size_o, expected_size(ld_op[idx]));
  endtask

  task automatic issue_load(input int idx);
    drive_load(idx);
    wait_pop(idx);
  endtask

  task automatic drop_valid();
    @(negedge clk_i);
    valid_i = 1'b0;
  endtask

  // one response pulse for the slot of load idx
  task automatic respond_load(input int idx, input logic exp_valid);
    @(negedge clk_i);
    data_rvalid_i = 1'b1;
    data_rid_i    = ld_slot[idx];
    data_rdata_i  = ld_data[idx];
    #1;
    check_bit("valid_o", valid_o, exp_valid);
    if (exp_valid) begin
      check_id("trans_id_o", trans_id_o, ld_id[idx]);
      check_result("result_o", result_o,
                   expected_load(ld_data[idx], ld_addr[idx][2:0], ld_op[idx]));
    end
    @(negedge clk_i);
    data_rvalid_i = 1'b0;
  endtask

  // tag must follow each grant by one cycle, and only then unless killed
  always @(negedge clk_i) begin
    #1;
    if (rst_ni) begin
      if (tag_due) begin
        check_bit("tag_valid_o", tag_valid_o, 1'b1);
        check_tag("address_tag_o", address_tag_o, exp_tag);
      end else if (!kill_req_o) begin
        check_bit("tag_valid_o", tag_valid_o, 1'b0);
      end
      if (pop_ld_o) pop_count++;
      if (tag_valid_o) tag_count++;
      tag_due = pop_ld_o;
      exp_tag = vaddr_i[DCACHE_INDEX_WIDTH +: DCACHE_TAG_WIDTH];
    end
  end

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic test_all_ops();
    for (int k = 0; k < 7; k++) begin
      ld_op[0] = load_op_e'(3'(k));
      for (int off = 0; off < 8; off += op_bytes(ld_op[0])) begin
        ld_addr[0]      = vaddr_t'({next_rand(), next_rand()});
        ld_addr[0][2:0] = 3'(off);
        ld_data[0]      = {next_rand(), next_rand()};
        ld_id[0]        = trans_id_t'(next_rand());
        issue_load(0);
        drop_valid();
        respond_load(0, 1'b1);
      end
    end
  endtask

  task automatic test_page_offset_stall();
    make_load(0);
    drive_load(0);
    page_offset_matches_i = 1'b1;
    repeat (4) begin
      #1;
      check_bit("data_req_o", data_req_o, 1'b0);
      check_bit("pop_ld_o", pop_ld_o, 1'b0);
      @(negedge clk_i);
    end
    page_offset_matches_i = 1'b0;
    wait_pop(0);
    drop_valid();
    respond_load(0, 1'b1);
  endtask

  task automatic test_back_pressure();
    for (int i = 0; i <= NrEntries; i++) make_load(i);
    for (int i = 0; i < NrEntries; i++) begin
      issue_load(i);
      // an empty buffer fills from slot 0 upwards
      check_slot("data_id_o", ld_slot[i], IdWidth'(i));
    end
    // one more load than slots, it must wait
    drive_load(NrEntries);
    repeat (3) begin
      #1;
      check_bit("pop_ld_o", pop_ld_o, 1'b0);
      check_bit("data_req_o", data_req_o, 1'b0);
      @(negedge clk_i);
    end
    // freeing the last slot lets the waiting load in
    respond_load(NrEntries - 1, 1'b1);
    wait_pop(NrEntries);
    // the slot just freed is the only free one
    check_slot("data_id_o", ld_slot[NrEntries], IdWidth'(NrEntries - 1));
    drop_valid();
    for (int i = NrEntries - 2; i >= 0; i--) respond_load(i, 1'b1);
    respond_load(NrEntries, 1'b1);
  endtask

  task automatic test_flush();
    make_load(0);
    make_load(1);
    issue_load(0);
    issue_load(1);
    // flush while the second tag is going out
    @(negedge clk_i);
    valid_i = 1'b0;
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    #1;
    check_bit("kill_req_o", kill_req_o, 1'b1);
    check_bit("tag_valid_o", tag_valid_o, 1'b1);
    respond_load(0, 1'b0);
    respond_load(1, 1'b0);
    make_load(2);
    issue_load(2);
    drop_valid();
    respond_load(2, 1'b1);
  endtask

  task automatic test_grant_delay();
    int pops0;
    int tags0;
    make_load(0);
    @(posedge clk_i);
    pops0 = pop_count;
    tags0 = tag_count;
    drive_load(0);
    data_gnt_i = 1'b0;
    repeat (5) begin
      #1;
      check_bit("data_req_o", data_req_o, 1'b1);
      check_bit("pop_ld_o", pop_ld_o, 1'b0);
      @(negedge clk_i);
    end
    data_gnt_i = 1'b1;
    wait_pop(0);
    drop_valid();
    repeat (3) @(posedge clk_i);
    check_count("pop_ld_o pulses", pop_count - pops0, 1);
    check_count("tag_valid_o pulses", tag_count - tags0, 1);
    respond_load(0, 1'b1);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    clk_i                 = 1'b0;
    rst_ni                = 1'b0;
    flush_i               = 1'b0;
    valid_i               = 1'b0;
    trans_id_i            = '0;
    vaddr_i               = '0;
    op_i                  = LB;
    be_i                  = '0;
    page_offset_matches_i = 1'b0;
    data_gnt_i            = 1'b1;
    data_rvalid_i         = 1'b0;
    data_rid_i            = '0;
    data_rdata_i          = '0;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;

    test_all_ops();
    test_page_offset_stall();
    test_back_pressure();
    test_flush();
    test_grant_delay();

    repeat (2) @(negedge clk_i);
    $display("Test completed successfully");
    $finish;
  end

  initial begin
    #(TimeoutNs);
    fail_run("timeout: the tests did not finish in their cycle budget");
  end

endmodule
